// ==== vlog.f ====
+incdir+tb
src/pktgen_pkg.sv
src/flow_table.sv
src/header_builder.sv
src/tx_shaper.sv
src/frame_sequencer.sv
src/tx_counters.sv
src/pktgen_top.sv
tb/pktgen_tb.sv

// ==== tb/pktgen_ref.svh ====
// Packet generator reference model

`ifndef PKTGEN_REF_SVH
`define PKTGEN_REF_SVH

////////////////////////////////////////////////////////////
// Random source

// Galois LFSR, polynomial x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

////////////////////////////////////////////////////////////
// Expected frame contents

// Byte p of the frame, counted from the first destination MAC byte
function automatic logic [7:0] frame_byte(input flow_def_t d, input int p);
    logic [7:0] hb [$];
    int k;
    for (k = 0; k < MAC_BYTES; k++) hb.push_back(d.mac_da[8*(MAC_BYTES-1-k) +: 8]);
    for (k = 0; k < MAC_BYTES; k++) hb.push_back(d.mac_sa[8*(MAC_BYTES-1-k) +: 8]);
    if (d.vlan_valid) begin
        for (k = 0; k < VLAN_BYTES; k++) hb.push_back(d.vlan_tag[8*(VLAN_BYTES-1-k) +: 8]);
    end
    for (k = 0; k < ETYPE_BYTES; k++) hb.push_back(d.ether_type[8*(ETYPE_BYTES-1-k) +: 8]);
    // Labels in order, as many as the count says
    if (d.mpls_cnt >= 2'd1) begin
        for (k = 0; k < MPLS_BYTES; k++) hb.push_back(d.mpls_label0[8*(MPLS_BYTES-1-k) +: 8]);
    end
    if (d.mpls_cnt >= 2'd2) begin
        for (k = 0; k < MPLS_BYTES; k++) hb.push_back(d.mpls_label1[8*(MPLS_BYTES-1-k) +: 8]);
    end
    for (k = 0; k < IPV4_BYTES; k++) hb.push_back(d.ipv4[8*(IPV4_BYTES-1-k) +: 8]);
    if (p < hb.size()) begin
        return hb[p];
    end
    return d.payload;
endfunction

// Byte enables of the closing word, frame byte 0 of a word sits in keep[7]
function automatic keep_t last_keep(input int len);
    keep_t k;
    int b;
    k = '0;
    if (len % WORD_BYTES == 0) begin
        return '1;
    end
    for (b = 0; b < len % WORD_BYTES; b++) begin
        k[WORD_BYTES-1-b] = 1'b1;
    end
    return k;
endfunction

`endif

// ==== tb/pktgen_tb.sv ====
// Packet generator testbench

`timescale 1ns/1ps

module pktgen_tb;
    import pktgen_pkg::*;
    `include "pktgen_ref.svh"

    localparam time   CLK_PERIOD   = 20ns;
    localparam time   DRIVE_DELAY  = 2ns;
    localparam rate_t FULL_RATE    = 20'hF_FFFF;
    // 1.5 bytes per clock
    localparam rate_t SHAPE_RATE   = 20'h1_8000;
    localparam int    RUN_A_FRAMES = 40;
    localparam int    FIN_1_FRAMES = 7;
    localparam int    FIN_2_FRAMES = 3;
    localparam int    SHAPE_CYCLES = 1000;
    localparam int    SHAPE_SLACK  = 2*MAX_HDR_BYTES + 200;
    localparam int    MAX_WORDS    = 25;
    localparam int    TOTAL_FRAMES = RUN_A_FRAMES + FIN_1_FRAMES + FIN_2_FRAMES
                                   + SHAPE_CYCLES*3/(2*64) + 4;
    localparam int    WATCHDOG_CYCLES = TOTAL_FRAMES*MAX_WORDS*40 + SHAPE_CYCLES + 1000;

    logic      packet_out;
    logic      rst_n;
    gen_cfg_t  cfg;
    flow_wr_t  flow_wr;
    logic      flow_wr_valid;
    pkt_word_t pkt;
    logic      pkt_valid;
    logic      pkt_ready;
    logic      stat_sample;
    pkt_cnt_t  stat_pkts;
    byte_cnt_t stat_bytes;

    flow_def_t   flows [NUM_FLOWS];
    logic [31:0] lfsr;
    logic        ready_mode;
    int          errors;
    int          checks;
    int          frames_seen;
    longint      exp_pkts;
    longint      exp_bytes;
    flow_idx_t   exp_flow;
    int          word_idx;
    logic        held;
    pkt_word_t   held_word;
    logic        shaping;
    longint      shape_cycles;
    longint      shape_bytes;

    pktgen_top i_dut (
        .packet_out    (packet_out),
        .rst_n         (rst_n),
        .cfg           (cfg),
        .flow_wr       (flow_wr),
        .flow_wr_valid (flow_wr_valid),
        .pkt           (pkt),
        .pkt_valid     (pkt_valid),
        .pkt_ready     (pkt_ready),
        .stat_sample   (stat_sample),
        .stat_pkts     (stat_pkts),
        .stat_bytes    (stat_bytes)
    );

    initial begin
        packet_out = 1'b0;
        forever #(CLK_PERIOD/2) packet_out = ~packet_out;
    end

    ////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    task automatic report_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        errors++;
        $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name,
                 expected, actual);
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    // Covers every VLAN and MPLS pairing across the table
    function automatic flow_def_t make_flow(input int i);
        flow_def_t d;
        int k;
        d.mac_da[47:32] = 16'(rand_bits(16));
        d.mac_da[31:0]  = rand_bits(32);
        d.mac_sa[47:32] = 16'(rand_bits(16));
        d.mac_sa[31:0]  = rand_bits(32);
        d.vlan_valid    = i[0];
        d.vlan_tag      = {16'h8100, 16'(rand_bits(16))};
        d.mpls_cnt      = 2'((i >> 1) % 3);
        d.ether_type    = (d.mpls_cnt != 2'd0) ? 16'h8847 : 16'h0800;
        d.mpls_label0   = rand_bits(32);
        d.mpls_label1   = rand_bits(32);
        for (k = 0; k < 5; k++) begin
            d.ipv4[32*k +: 32] = rand_bits(32);
        end
        d.frame_len = frame_len_t'(64 + rand_bits(8) % 137);
        if (i == 0) d.frame_len = 14'd64;
        if (i == 1) d.frame_len = 14'd200;
        d.payload = 8'(rand_bits(8));
        return d;
    endfunction

    task automatic load_flows();
        int i;
        for (i = 0; i < NUM_FLOWS; i++) begin
            flows[i] = make_flow(i);
            flow_wr.idx   = flow_idx_t'(i);
            flow_wr.def   = flows[i];
            flow_wr_valid = 1'b1;
            @(posedge packet_out);
            #(DRIVE_DELAY);
        end
        flow_wr_valid = 1'b0;
    endtask

    task automatic start_run(input logic finite, input int count, input int last,
                             input rate_t rate);
        int n;
        exp_flow         = '0;
        word_idx         = 0;
        cfg.finite       = finite;
        cfg.frame_count  = 28'(count);
        cfg.last_flow    = flow_idx_t'(last);
        cfg.rate         = rate;
        cfg.tx_en        = 1'b1;
        n = 0;
        while (!pkt_valid && n < 5) begin
            @(posedge packet_out);
            #(DRIVE_DELAY);
            n++;
        end
        if (!pkt_valid) report_problem("no first word within 5 cycles of transmit enable");
    endtask

    task automatic wait_frames(input int target);
        while (frames_seen < target) begin
            @(posedge packet_out);
            #(DRIVE_DELAY);
        end
    endtask

    // Idle once valid has stayed low for a few cycles with enable off
    task automatic stop_and_drain();
        int quiet;
        cfg.tx_en = 1'b0;
        quiet = 0;
        while (quiet < 4) begin
            @(posedge packet_out);
            #(DRIVE_DELAY);
            quiet = pkt_valid ? 0 : quiet + 1;
        end
        if (word_idx != 0) report_problem("stream went idle in the middle of a frame");
    endtask

    task automatic sample_and_check(input longint pkts, input longint bytes);
        stat_sample = 1'b1;
        @(posedge packet_out);
        #(DRIVE_DELAY);
        stat_sample = 1'b0;
        checks++;
        if (stat_pkts != pkt_cnt_t'(pkts)) report_value("stat_pkts", pkts, stat_pkts);
        if (stat_bytes != byte_cnt_t'(bytes)) report_value("stat_bytes", bytes, stat_bytes);
    endtask

    task automatic check_counters();
        sample_and_check(exp_pkts, exp_bytes);
        exp_pkts  = 0;
        exp_bytes = 0;
        sample_and_check(0, 0);
    endtask

    task automatic finite_run(input int count, input int last);
        int start;
        int i;
        start = frames_seen;
        start_run(1'b1, count, last, FULL_RATE);
        wait_frames(start + count);
        // Held in DONE while enable stays high
        for (i = 0; i < 40; i++) begin
            @(posedge packet_out);
            #(DRIVE_DELAY);
            if (pkt_valid) begin
                report_problem("pkt_valid rose after the finite frame count was sent");
                break;
            end
        end
        stop_and_drain();
        if (frames_seen != start + count) begin
            report_value("finite frames", count, frames_seen - start);
        end
        check_counters();
    endtask

    ////////////////////////////////////////////////////////////
    // Comparison

    task automatic check_word();
        flow_def_t  d;
        int         len;
        int         pos;
        int         b;
        logic       exp_last;
        keep_t      exp_keep;
        data_word_t exp_data;
        data_word_t mask;
        checks++;
        d        = flows[exp_flow];
        len      = int'(d.frame_len);
        exp_last = (word_idx == (len + 7) / 8 - 1);
        exp_keep = exp_last ? last_keep(len) : '1;
        exp_data = '0;
        mask     = '0;
        for (b = 0; b < WORD_BYTES; b++) begin
            pos = WORD_BYTES*word_idx + b;
            if (pos < len) begin
                exp_data[8*(WORD_BYTES-1-b) +: 8] = frame_byte(d, pos);
                mask[8*(WORD_BYTES-1-b) +: 8]     = 8'hFF;
            end
        end
        if (pkt.flow != exp_flow) report_value("pkt.flow", exp_flow, pkt.flow);
        if (pkt.last != exp_last) report_value("pkt.last", exp_last, pkt.last);
        if (pkt.keep != exp_keep) report_value("pkt.keep", exp_keep, pkt.keep);
        if ((pkt.data & mask) != exp_data) report_value("pkt.data", exp_data, pkt.data & mask);
        if (exp_last) begin
            word_idx = 0;
            exp_pkts++;
            exp_bytes += len;
            frames_seen++;
            exp_flow = (exp_flow == cfg.last_flow) ? '0 : exp_flow + 1'b1;
        end else begin
            word_idx++;
        end
    endtask

    // Words are sampled mid-cycle and one with valid and ready moves on the next edge
    always @(negedge packet_out) begin
        if (rst_n) begin
            if (held) begin
                if (!pkt_valid) begin
                    report_problem("pkt_valid dropped while a word was stalled");
                end else begin
                    if (pkt.data != held_word.data)
                        report_value("stalled pkt.data", held_word.data, pkt.data);
                    if ({pkt.keep, pkt.last, pkt.flow} != {held_word.keep, held_word.last,
                                                           held_word.flow})
                        report_value("stalled pkt.keep/last/flow",
                                     {held_word.keep, held_word.last, held_word.flow},
                                     {pkt.keep, pkt.last, pkt.flow});
                end
            end
            if (pkt_valid && pkt_ready) check_word();
            held      = pkt_valid && !pkt_ready;
            held_word = pkt;
            if (shaping) begin
                shape_cycles++;
                if (pkt_valid && pkt_ready) shape_bytes += $countones(pkt.keep);
                if (2*shape_bytes > 3*shape_cycles + 2*SHAPE_SLACK)
                    report_problem($sformatf("shaper let %0d bytes through in %0d cycles",
                                             shape_bytes, shape_cycles));
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    always @(posedge packet_out) begin : drive_ready
        logic random_now;
        random_now = ready_mode;
        #(DRIVE_DELAY);
        pkt_ready = random_now ? (rand_bits(2) != 32'd0) : 1'b1;
    end

    initial begin
        rst_n         = 1'b0;
        cfg           = '0;
        flow_wr       = '0;
        flow_wr_valid = 1'b0;
        pkt_ready     = 1'b0;
        stat_sample   = 1'b0;
        ready_mode    = 1'b0;
        lfsr          = 32'h55d84209;
        errors        = 0;
        checks        = 0;
        frames_seen   = 0;
        exp_pkts      = 0;
        exp_bytes     = 0;
        exp_flow      = '0;
        word_idx      = 0;
        held          = 1'b0;
        shaping       = 1'b0;
        shape_cycles  = 0;
        shape_bytes   = 0;
        repeat (2) @(posedge packet_out);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        @(negedge packet_out);
        if (pkt_valid) report_value("pkt_valid after reset", 0, pkt_valid);
        if (stat_pkts != '0) report_value("stat_pkts after reset", 0, stat_pkts);
        if (stat_bytes != '0) report_value("stat_bytes after reset", 0, stat_bytes);
        @(posedge packet_out);
        #(DRIVE_DELAY);
        load_flows();

        // Continuous mode over all flows with random back-pressure
        ready_mode = 1'b1;
        start_run(1'b0, 0, NUM_FLOWS - 1, FULL_RATE);
        wait_frames(RUN_A_FRAMES);
        stop_and_drain();
        check_counters();

        // Finite mode run twice so the enable toggle restarts it
        finite_run(FIN_1_FRAMES, 4);
        finite_run(FIN_2_FRAMES, 2);

        // Shaped at 1.5 bytes per clock with ready held high
        ready_mode = 1'b0;
        @(posedge packet_out);
        #(DRIVE_DELAY);
        shaping = 1'b1;
        start_run(1'b0, 0, NUM_FLOWS - 1, SHAPE_RATE);
        repeat (SHAPE_CYCLES) @(posedge packet_out);
        #(DRIVE_DELAY);
        shaping = 1'b0;
        if (2*shape_bytes < shape_cycles) report_problem("shaped stream carried too little traffic");
        stop_and_drain();
        check_counters();

        $display("Summary: %0d checks, %0d frames, %0d errors", checks, frames_seen, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Summary: %0d checks, %0d frames, %0d errors", checks, frames_seen, errors);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== src/pktgen_top.sv ====
// Packet generator top level

`timescale 1ns/1ps

module pktgen_top (
    input  logic                  packet_out,
    input  logic                  rst_n,
    input  pktgen_pkg::gen_cfg_t  cfg,
    input  pktgen_pkg::flow_wr_t  flow_wr,
    input  logic                  flow_wr_valid,
    output pktgen_pkg::pkt_word_t pkt,
    output logic                  pkt_valid,
    input  logic                  pkt_ready,
    input  logic                  stat_sample,
    output pktgen_pkg::pkt_cnt_t  stat_pkts,
    output pktgen_pkg::byte_cnt_t stat_bytes
);
    import pktgen_pkg::*;

    flow_idx_t   rd_idx;
    flow_def_t   rd_def;
    frame_desc_t desc;
    frame_len_t  frame_len;
    logic        shaper_ok;
    logic        active;
    logic        word_acc;

    // Word handed over on this edge
    assign word_acc = pkt_valid && pkt_ready;

    ////////////////////////////////////////////////////////////
    // Input side

    flow_table i_flow_table (
        .packet_out    (packet_out),
        .rst_n         (rst_n),
        .flow_wr       (flow_wr),
        .flow_wr_valid (flow_wr_valid),
        .rd_idx        (rd_idx),
        .rd_def        (rd_def)
    );

    ////////////////////////////////////////////////////////////
    // Processing

    header_builder i_header_builder (
        .packet_out (packet_out),
        .rst_n      (rst_n),
        .rd_def     (rd_def),
        .desc       (desc)
    );

    frame_sequencer i_frame_sequencer (
        .packet_out (packet_out),
        .rst_n      (rst_n),
        .cfg        (cfg),
        .desc       (desc),
        .shaper_ok  (shaper_ok),
        .pkt_ready  (pkt_ready),
        .rd_idx     (rd_idx),
        .pkt        (pkt),
        .pkt_valid  (pkt_valid),
        .active     (active),
        .frame_len  (frame_len)
    );

    tx_shaper i_tx_shaper (
        .packet_out  (packet_out),
        .rst_n       (rst_n),
        .active      (active),
        .rate        (cfg.rate),
        .debit_keep  (pkt.keep),
        .debit_valid (word_acc),
        .shaper_ok   (shaper_ok)
    );

    ////////////////////////////////////////////////////////////
    // Output side

    tx_counters i_tx_counters (
        .packet_out  (packet_out),
        .rst_n       (rst_n),
        .word_valid  (word_acc),
        .word_last   (pkt.last),
        .frame_len   (frame_len),
        .stat_sample (stat_sample),
        .stat_pkts   (stat_pkts),
        .stat_bytes  (stat_bytes)
    );

endmodule

// ==== src/tx_counters.sv ====
// Aggregate transmit counters

`timescale 1ns/1ps

module tx_counters (
    input  logic                   packet_out,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  logic                   word_last,
    input  pktgen_pkg::frame_len_t frame_len,
    input  logic                   stat_sample,
    output pktgen_pkg::pkt_cnt_t   stat_pkts,
    output pktgen_pkg::byte_cnt_t  stat_bytes
);
    import pktgen_pkg::*;

    pkt_cnt_t  live_pkts;
    byte_cnt_t live_bytes;
    logic      frame_done;

    assign frame_done = word_valid && word_last;

    always_ff @(posedge packet_out or negedge rst_n) begin
        if (!rst_n) begin
            live_pkts  <= '0;
            live_bytes <= '0;
            stat_pkts  <= '0;
            stat_bytes <= '0;
        end else if (stat_sample) begin
            stat_pkts  <= live_pkts;
            stat_bytes <= live_bytes;
            // A frame ending on the sample edge opens the new interval
            if (frame_done) begin
                live_pkts  <= pkt_cnt_t'(1);
                live_bytes <= byte_cnt_t'(frame_len);
            end else begin
                live_pkts  <= '0;
                live_bytes <= '0;
            end
        end else if (frame_done) begin
            if (live_pkts != '1) begin
                live_pkts <= live_pkts + 1'b1;
            end
            live_bytes <= live_bytes + byte_cnt_t'(frame_len);
        end
    end

endmodule

// ==== src/frame_sequencer.sv ====
// Frame sequencer FSM

`timescale 1ns/1ps

module frame_sequencer (
    input  logic                    packet_out,
    input  logic                    rst_n,
    input  pktgen_pkg::gen_cfg_t    cfg,
    input  pktgen_pkg::frame_desc_t desc,
    input  logic                    shaper_ok,
    input  logic                    pkt_ready,
    output pktgen_pkg::flow_idx_t   rd_idx,
    output pktgen_pkg::pkt_word_t   pkt,
    output logic                    pkt_valid,
    output logic                    active,
    output pktgen_pkg::frame_len_t  frame_len
);
    import pktgen_pkg::*;

    seq_state_t  state;
    logic        fetch_done;
    flow_idx_t   cur_flow;
    flow_idx_t   next_idx;
    frame_desc_t cur_desc;
    word_cnt_t   word_cnt;
    word_cnt_t   last_word;
    word_cnt_t   hdr_words;
    logic        finite_q;
    logic [27:0] remaining;
    logic        accept;
    logic        frame_end;
    logic        more;
    logic        start_frame;
    header_vec_t hdr_shift;
    data_word_t  hdr_word;

    ////////////////////////////////////////////////////////////
    // Frame bookkeeping

    assign accept    = pkt_valid && pkt_ready;
    assign frame_end = accept && pkt.last;
    assign more      = cfg.tx_en && !(finite_q && remaining == '0);
    assign next_idx  = (rd_idx == cfg.last_flow) ? '0 : rd_idx + 1'b1;

    // Headers are 34 + 4n bytes, so they never end on a word edge
    assign hdr_words = word_cnt_t'(cur_desc.hdr_len[5:3]);
    assign last_word = word_cnt_t'((cur_desc.frame_len - 1'b1) >> 3);
    assign frame_len = cur_desc.frame_len;

    assign pkt_valid = (state == HEADER) || (state == MIXED) || (state == PAYLOAD);
    assign active    = (state != IDLE) && (state != DONE);

    always_comb begin
        case (state)
            FETCH:       start_frame = fetch_done && cfg.tx_en;
            WAIT_SHAPER: start_frame = cfg.tx_en && shaper_ok;
            PAYLOAD:     start_frame = frame_end && more && shaper_ok;
            default:     start_frame = 1'b0;
        endcase
    end

    // Next flow is fetched from the end of the header on, which
    // needs frames of 64 bytes or more
    always_ff @(posedge packet_out) begin
        if (start_frame) begin
            cur_desc <= desc;
        end
    end

    ////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge packet_out or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            fetch_done <= 1'b0;
            rd_idx     <= '0;
            cur_flow   <= '0;
            word_cnt   <= '0;
            finite_q   <= 1'b0;
            remaining  <= '0;
        end else begin
            if (frame_end && remaining != '0) begin
                remaining <= remaining - 1'b1;
            end
            if (start_frame) begin
                state    <= HEADER;
                cur_flow <= rd_idx;
                word_cnt <= '0;
            end else begin
                case (state)
                    IDLE: begin
                        rd_idx     <= '0;
                        fetch_done <= 1'b0;
                        finite_q   <= cfg.finite;
                        remaining  <= cfg.frame_count - 1'b1;
                        if (cfg.tx_en) begin
                            state <= FETCH;
                        end
                    end
                    FETCH: begin
                        fetch_done <= 1'b1;
                        if (!cfg.tx_en) begin
                            state <= IDLE;
                        end
                    end
                    HEADER: begin
                        if (accept) begin
                            word_cnt <= word_cnt + 1'b1;
                            if (word_cnt + 1'b1 == hdr_words) begin
                                state  <= MIXED;
                                rd_idx <= next_idx;
                            end
                        end
                    end
                    MIXED: begin
                        if (accept) begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= PAYLOAD;
                        end
                    end
                    PAYLOAD: begin
                        if (accept) begin
                            word_cnt <= word_cnt + 1'b1;
                            if (pkt.last) begin
                                if (!cfg.tx_en) begin
                                    state <= IDLE;
                                end else if (!more) begin
                                    state <= DONE;
                                end else begin
                                    state <= WAIT_SHAPER;
                                end
                            end
                        end
                    end
                    WAIT_SHAPER, DONE: begin
                        if (!cfg.tx_en) begin
                            state <= IDLE;
                        end
                    end
                    default: state <= IDLE;
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output word

    // Header word at the current word index, byte 0 in data[63:56]
    assign hdr_shift = cur_desc.hdr << {word_cnt[2:0], 6'd0};
    assign hdr_word  = hdr_shift[$left(hdr_shift) -: 8*WORD_BYTES];

    always_comb begin
        pkt      = '0;
        pkt.flow = cur_flow;
        pkt.last = (state == PAYLOAD) && (word_cnt == last_word);
        pkt.keep = '1;
        if (pkt.last && cur_desc.frame_len[2:0] != 3'd0) begin
            pkt.keep = ~({WORD_BYTES{1'b1}} >> cur_desc.frame_len[2:0]);
        end
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (state == HEADER || (state == MIXED && b < int'(cur_desc.hdr_len[2:0]))) begin
                pkt.data[8*(WORD_BYTES-1-b) +: 8] = hdr_word[8*(WORD_BYTES-1-b) +: 8];
            end else begin
                pkt.data[8*(WORD_BYTES-1-b) +: 8] = cur_desc.payload;
            end
        end
    end

endmodule

// ==== src/tx_shaper.sv ====
// Byte-credit rate shaper

`timescale 1ns/1ps

module tx_shaper (
    input  logic              packet_out,
    input  logic              rst_n,
    input  logic              active,
    input  pktgen_pkg::rate_t rate,
    input  pktgen_pkg::keep_t debit_keep,
    input  logic              debit_valid,
    output logic              shaper_ok
);

    // Signed 16.16 byte credit
    logic [31:0] acc;
    logic [31:0] credit;
    logic [31:0] debit;
    logic        saturated;

    ////////////////////////////////////////////////////////////
    // Credit and debit

    // Stop earning once the credit reaches half the positive range
    assign saturated = (acc[31:30] == 2'b01);
    assign credit    = saturated ? 32'd0 : {12'd0, rate};

    // Whole bytes of the accepted word
    assign debit = debit_valid ? {12'd0, 4'($countones(debit_keep)), 16'd0} : 32'd0;

    always_ff @(posedge packet_out or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (!active) begin
            acc <= '0;
        end else begin
            acc <= acc + credit - debit;
        end
    end

    // Frames may start while the credit is not negative
    assign shaper_ok = ~acc[31];

endmodule

// ==== src/header_builder.sv ====
// Header assembly stage

`timescale 1ns/1ps

module header_builder (
    input  logic                    packet_out,
    input  logic                    rst_n,
    input  pktgen_pkg::flow_def_t   rd_def,
    output pktgen_pkg::frame_desc_t desc
);
    import pktgen_pkg::*;

    header_vec_t hdr;
    hdr_len_t    hdr_len;

    ////////////////////////////////////////////////////////////
    // Field packing

    // First header byte lands in the top byte of hdr, each
    // field goes right behind the previous one
    always_comb begin
        hdr = '0;
        hdr[$left(hdr) -: 16*MAC_BYTES] = {rd_def.mac_da, rd_def.mac_sa};
        hdr_len = hdr_len_t'(2*MAC_BYTES);

        if (rd_def.vlan_valid) begin
            hdr[$left(hdr) - 8*hdr_len -: 8*VLAN_BYTES] = rd_def.vlan_tag;
            hdr_len = hdr_len + hdr_len_t'(VLAN_BYTES);
        end

        hdr[$left(hdr) - 8*hdr_len -: 8*ETYPE_BYTES] = rd_def.ether_type;
        hdr_len = hdr_len + hdr_len_t'(ETYPE_BYTES);

        // Label count of 0, 1 or 2
        if (rd_def.mpls_cnt != 2'd0) begin
            hdr[$left(hdr) - 8*hdr_len -: 8*MPLS_BYTES] = rd_def.mpls_label0;
            hdr_len = hdr_len + hdr_len_t'(MPLS_BYTES);
        end
        if (rd_def.mpls_cnt[1]) begin
            hdr[$left(hdr) - 8*hdr_len -: 8*MPLS_BYTES] = rd_def.mpls_label1;
            hdr_len = hdr_len + hdr_len_t'(MPLS_BYTES);
        end

        hdr[$left(hdr) - 8*hdr_len -: 8*IPV4_BYTES] = rd_def.ipv4;
        hdr_len = hdr_len + hdr_len_t'(IPV4_BYTES);
    end

    ////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge packet_out or negedge rst_n) begin
        if (!rst_n) begin
            desc <= '0;
        end else begin
            desc.hdr       <= hdr;
            desc.hdr_len   <= hdr_len;
            desc.frame_len <= rd_def.frame_len;
            desc.payload   <= rd_def.payload;
        end
    end

endmodule

// ==== src/flow_table.sv ====
// Flow definition table

`timescale 1ns/1ps

module flow_table (
    input  logic                  packet_out,
    input  logic                  rst_n,
    input  pktgen_pkg::flow_wr_t  flow_wr,
    input  logic                  flow_wr_valid,
    input  pktgen_pkg::flow_idx_t rd_idx,
    output pktgen_pkg::flow_def_t rd_def
);
    import pktgen_pkg::*;

    flow_def_t mem [NUM_FLOWS];

    ////////////////////////////////////////////////////////////
    // Write port

    // Always accepts, no back-pressure on the loader
    always_ff @(posedge packet_out) begin
        if (flow_wr_valid) begin
            mem[flow_wr.idx] <= flow_wr.def;
        end
    end

    ////////////////////////////////////////////////////////////
    // Read port

    // One cycle from rd_idx to rd_def
    always_ff @(posedge packet_out or negedge rst_n) begin
        if (!rst_n) begin
            rd_def <= '0;
        end else begin
            rd_def <= mem[rd_idx];
        end
    end

endmodule

// ==== src/pktgen_pkg.sv ====
// Packet generator shared types

package pktgen_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes

    localparam int NUM_FLOWS   = 16;
    localparam int FLOW_IDX_W  = 4;
    localparam int WORD_BYTES  = 8;

    localparam int MAC_BYTES   = 6;
    localparam int VLAN_BYTES  = 4;
    localparam int ETYPE_BYTES = 2;
    localparam int MPLS_BYTES  = 4;
    localparam int IPV4_BYTES  = 20;

    // Both addresses, one VLAN tag, two labels and IPv4 (46 bytes)
    localparam int MAX_HDR_BYTES = 2*MAC_BYTES + VLAN_BYTES + ETYPE_BYTES
                                 + 2*MPLS_BYTES + IPV4_BYTES;

    ////////////////////////////////////////////////////////////
    // Vector types

    typedef logic [FLOW_IDX_W-1:0]      flow_idx_t;
    typedef logic [13:0]                frame_len_t;
    typedef logic [10:0]                word_cnt_t;
    typedef logic [5:0]                 hdr_len_t;
    typedef logic [8*WORD_BYTES-1:0]    data_word_t;
    typedef logic [WORD_BYTES-1:0]      keep_t;
    typedef logic [8*MAX_HDR_BYTES-1:0] header_vec_t;
    // Bytes per clock, 4 whole and 16 fractional bits
    typedef logic [19:0]                rate_t;
    typedef logic [47:0]                pkt_cnt_t;
    typedef logic [54:0]                byte_cnt_t;

    ////////////////////////////////////////////////////////////
    // Structs

    typedef struct packed {
        logic [8*MAC_BYTES-1:0]   mac_da;
        logic [8*MAC_BYTES-1:0]   mac_sa;
        logic [8*ETYPE_BYTES-1:0] ether_type;
        logic                     vlan_valid;
        logic [8*VLAN_BYTES-1:0]  vlan_tag;
        logic [1:0]               mpls_cnt;
        logic [8*MPLS_BYTES-1:0]  mpls_label0;
        logic [8*MPLS_BYTES-1:0]  mpls_label1;
        logic [8*IPV4_BYTES-1:0]  ipv4;
        frame_len_t               frame_len;
        logic [7:0]               payload;
    } flow_def_t;

    typedef struct packed {
        flow_idx_t idx;
        flow_def_t def;
    } flow_wr_t;

    typedef struct packed {
        header_vec_t hdr;
        hdr_len_t    hdr_len;
        frame_len_t  frame_len;
        logic [7:0]  payload;
    } frame_desc_t;

    typedef struct packed {
        logic        tx_en;
        logic        finite;
        logic [27:0] frame_count;
        flow_idx_t   last_flow;
        rate_t       rate;
    } gen_cfg_t;

    typedef struct packed {
        data_word_t data;
        keep_t      keep;
        logic       last;
        flow_idx_t  flow;
    } pkt_word_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        HEADER,
        MIXED,
        PAYLOAD,
        WAIT_SHAPER,
        DONE
    } seq_state_t;

endpackage
